// ==== project.f ====
logic/gpu_types_pkg.sv
logic/gpu_ops_pkg.sv
logic/stage_if.sv
logic/single_cycle_stage.sv
logic/dcache_data_stage.sv
logic/writeback_stage.sv
logic/vector_register_file.sv
logic/writeback_subsystem.sv
tests/wb_checker.sv
tests/tb_writeback.sv

// ==== Bender.yml ====
package:
  name: writeback_subsystem

sources:
  - logic/gpu_types_pkg.sv
  - logic/gpu_ops_pkg.sv
  - logic/stage_if.sv
  - logic/single_cycle_stage.sv
  - logic/dcache_data_stage.sv
  - logic/writeback_stage.sv
  - logic/vector_register_file.sv
  - logic/writeback_subsystem.sv
  - target: test
    files:
      - tests/wb_checker.sv
      - tests/tb_writeback.sv

// ==== tests/tb_writeback.sv ====
// Testbench for the pipeline tail, driving issue traffic and reading back registers
`timescale 1ns/1ps
`default_nettype none

module tb_writeback import gpu_types_pkg::*; import gpu_ops_pkg::*;
();

	localparam int CACHE_LINES = 16;
	localparam int CLK_PERIOD = 4;
	localparam scalar_t LOAD_LINE_ADDR = 32'h40;
	localparam scalar_t BLOCK_LINE_ADDR = 32'h60;

	// Issue and readback counts per test, used to size the watchdog
	localparam int ARITH_ISSUES = 40;
	localparam int COMPARE_ISSUES = 16;
	localparam int LOAD_STORE_ISSUES = 56;
	localparam int BLOCK_ISSUES = 4;
	localparam int ROLLBACK_ISSUES = 8;
	localparam int CALL_ISSUES = 4;
	localparam int READBACKS = 32 + NUM_THREADS * NUM_REGS;
	// Eight drains of about six cycles each
	localparam int DRAIN_CYCLES = 8 * 6;
	localparam int TOTAL_CYCLES = ARITH_ISSUES + COMPARE_ISSUES + LOAD_STORE_ISSUES
		+ BLOCK_ISSUES + ROLLBACK_ISSUES + CALL_ISSUES + READBACKS + DRAIN_CYCLES + 3;
	localparam int WATCHDOG_NS = TOTAL_CYCLES * CLK_PERIOD + 200;

	logic clk;
	logic reset;
	logic issue_valid;
	logic issue_is_mem;
	alu_op_t issue_op;
	memory_op_t issue_mem_op;
	logic issue_is_store;
	thread_idx_t issue_thread;
	register_idx_t issue_dest_reg;
	logic issue_dest_is_vector;
	scalar_t issue_pc;
	vector_t issue_operand_a;
	vector_t issue_operand_b;
	lane_mask_t issue_mask;
	scalar_t issue_addr;
	logic rollback_en;
	thread_idx_t rollback_thread;
	scalar_t rollback_pc;
	pipeline_sel_t rollback_pipeline;
	logic wb_en;
	thread_idx_t wb_thread;
	register_idx_t wb_reg;
	logic wb_is_vector;
	vector_t wb_value;
	lane_mask_t wb_mask;
	thread_idx_t read_thread;
	register_idx_t read_reg;
	vector_t read_value;
	logic read_check;
	int in_flight;
	int check_count;
	int error_count;
	integer seed;
	int tests_passed;
	int tests_failed;
	int errors_at_start;

	writeback_subsystem #(.CACHE_LINES(CACHE_LINES)) dut (
		.clk(clk), .reset(reset),
		.issue_valid(issue_valid), .issue_is_mem(issue_is_mem), .issue_op(issue_op),
		.issue_mem_op(issue_mem_op), .issue_is_store(issue_is_store),
		.issue_thread(issue_thread), .issue_dest_reg(issue_dest_reg),
		.issue_dest_is_vector(issue_dest_is_vector), .issue_pc(issue_pc),
		.issue_operand_a(issue_operand_a), .issue_operand_b(issue_operand_b),
		.issue_mask(issue_mask), .issue_addr(issue_addr),
		.rollback_en(rollback_en), .rollback_thread(rollback_thread),
		.rollback_pc(rollback_pc), .rollback_pipeline(rollback_pipeline),
		.wb_en(wb_en), .wb_thread(wb_thread), .wb_reg(wb_reg), .wb_is_vector(wb_is_vector),
		.wb_value(wb_value), .wb_mask(wb_mask),
		.read_thread(read_thread), .read_reg(read_reg), .read_value(read_value)
	);

	wb_checker #(.CACHE_LINES(CACHE_LINES)) u_checker (
		.clk(clk), .reset(reset),
		.issue_valid(issue_valid), .issue_is_mem(issue_is_mem), .issue_op(issue_op),
		.issue_mem_op(issue_mem_op), .issue_is_store(issue_is_store),
		.issue_thread(issue_thread), .issue_dest_reg(issue_dest_reg),
		.issue_dest_is_vector(issue_dest_is_vector), .issue_pc(issue_pc),
		.issue_operand_a(issue_operand_a), .issue_operand_b(issue_operand_b),
		.issue_mask(issue_mask), .issue_addr(issue_addr),
		.rollback_en(rollback_en), .rollback_thread(rollback_thread),
		.rollback_pc(rollback_pc), .rollback_pipeline(rollback_pipeline),
		.wb_en(wb_en), .wb_thread(wb_thread), .wb_reg(wb_reg), .wb_is_vector(wb_is_vector),
		.wb_value(wb_value), .wb_mask(wb_mask),
		.read_thread(read_thread), .read_reg(read_reg), .read_value(read_value),
		.read_check(read_check), .in_flight(in_flight), .check_count(check_count),
		.error_count(error_count)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
		$display("RESULT: FAIL");
		$finish;
	end

	function automatic vector_t random_vector();
		vector_t v;
		for (int lane = 0; lane < NUM_LANES; lane++)
			v[lane] = $random(seed);
		return v;
	endfunction

	function automatic alu_op_t random_arith_op();
		case ($unsigned($random(seed)) % 3)
			0: return OP_ADD;
			1: return OP_SUB;
			default: return OP_MOVE;
		endcase
	endfunction

	task automatic issue_arith(alu_op_t op, thread_idx_t thread, register_idx_t dest,
		logic is_vector, scalar_t pc, vector_t a, vector_t b, lane_mask_t mask);
		@(posedge clk);
		issue_valid <= 1'b1;
		issue_is_mem <= 1'b0;
		issue_op <= op;
		issue_thread <= thread;
		issue_dest_reg <= dest;
		issue_dest_is_vector <= is_vector;
		issue_pc <= pc;
		issue_operand_a <= a;
		issue_operand_b <= b;
		issue_mask <= mask;
	endtask

	task automatic issue_mem(memory_op_t op, logic is_store, thread_idx_t thread,
		register_idx_t dest, logic is_vector, scalar_t addr, vector_t b, lane_mask_t mask);
		@(posedge clk);
		issue_valid <= 1'b1;
		issue_is_mem <= 1'b1;
		issue_mem_op <= op;
		issue_is_store <= is_store;
		issue_thread <= thread;
		issue_dest_reg <= dest;
		issue_dest_is_vector <= is_vector;
		issue_addr <= addr;
		issue_operand_b <= b;
		issue_mask <= mask;
	endtask

	// Stop issuing and wait until every issued instruction has been checked
	task automatic wait_idle();
		@(posedge clk);
		issue_valid <= 1'b0;
		read_check <= 1'b0;
		while (in_flight != 0)
			@(posedge clk);
	endtask

	task automatic read_back(thread_idx_t thread, register_idx_t register);
		@(posedge clk);
		read_thread <= thread;
		read_reg <= register;
		read_check <= 1'b1;
	endtask

	task automatic finish_test(string name);
		if (error_count == errors_at_start)
		begin
			tests_passed++;
			$display("test %s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, error_count - errors_at_start);
		end
		errors_at_start = error_count;
	endtask

	initial
	begin
		vector_t a;
		vector_t b;
		scalar_t stored [4];
		seed = 80;
		tests_passed = 0;
		tests_failed = 0;
		errors_at_start = 0;
		issue_valid = 1'b0;
		issue_is_mem = 1'b0;
		issue_op = OP_ADD;
		issue_mem_op = MEM_B;
		issue_is_store = 1'b0;
		issue_thread = '0;
		issue_dest_reg = '0;
		issue_dest_is_vector = 1'b0;
		issue_pc = '0;
		issue_operand_a = '0;
		issue_operand_b = '0;
		issue_mask = '0;
		issue_addr = '0;
		read_thread = '0;
		read_reg = '0;
		read_check = 1'b0;
		reset = 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < ARITH_ISSUES; i++)
			issue_arith(random_arith_op(), thread_idx_t'($random(seed)),
				register_idx_t'($unsigned($random(seed)) % 8), 1'($random(seed)),
				$random(seed), random_vector(), random_vector(), lane_mask_t'($random(seed)));
		wait_idle();
		// Only the enabled lanes may have changed
		for (int t = 0; t < NUM_THREADS; t++)
			for (int r = 0; r < 8; r++)
				read_back(thread_idx_t'(t), register_idx_t'(r));
		wait_idle();
		finish_test("arithmetic");

		for (int i = 0; i < COMPARE_ISSUES; i++)
		begin
			a = random_vector();
			b = random_vector();
			// Copy some lanes over so that they compare equal
			for (int lane = 0; lane < NUM_LANES; lane++)
				if ($random(seed) & 1)
					b[lane] = a[lane];
			issue_arith(OP_CMPEQ, thread_idx_t'($random(seed)), register_idx_t'(8 + i % 4),
				1'b1, $random(seed), a, b, 4'hf);
		end
		wait_idle();
		finish_test("compare");

		stored[0] = 32'h807f_ff01;
		stored[1] = 32'h7f80_01ff;
		stored[2] = $random(seed);
		stored[3] = $random(seed);
		for (int w = 0; w < 4; w++)
		begin
			b = random_vector();
			b[0] = stored[w];
			issue_mem(MEM_L, 1'b1, 2'd0, 5'd0, 1'b0, LOAD_LINE_ADDR + 4 * w, b, 4'hf);
		end
		for (int off = 0; off < 16; off++)
		begin
			issue_mem(MEM_B, 1'b0, thread_idx_t'($random(seed)), 5'd12, 1'($random(seed)),
				LOAD_LINE_ADDR + off, '0, 4'hf);
			issue_mem(MEM_BX, 1'b0, thread_idx_t'($random(seed)), 5'd12, 1'($random(seed)),
				LOAD_LINE_ADDR + off, '0, 4'hf);
			if (off % 2 == 0)
			begin
				issue_mem(MEM_S, 1'b0, thread_idx_t'($random(seed)), 5'd12, 1'b1,
					LOAD_LINE_ADDR + off, '0, 4'hf);
				issue_mem(MEM_SX, 1'b0, thread_idx_t'($random(seed)), 5'd12, 1'b0,
					LOAD_LINE_ADDR + off, '0, 4'hf);
			end
			if (off % 4 == 0)
				issue_mem(MEM_L, 1'b0, thread_idx_t'($random(seed)), 5'd12, 1'b1,
					LOAD_LINE_ADDR + off, '0, 4'hf);
		end
		wait_idle();
		finish_test("scalar load");

		issue_mem(MEM_BLOCK, 1'b1, 2'd0, 5'd0, 1'b1, BLOCK_LINE_ADDR, random_vector(), 4'hf);
		for (int i = 0; i < BLOCK_ISSUES - 1; i++)
			issue_mem(MEM_BLOCK, 1'b0, thread_idx_t'($random(seed)), 5'd13, 1'b1,
				BLOCK_LINE_ADDR, '0, lane_mask_t'($random(seed)));
		wait_idle();
		finish_test("block load");

		for (int i = 0; i < ROLLBACK_ISSUES / 2; i++)
			issue_arith(random_arith_op(), thread_idx_t'($random(seed)), REG_PC,
				1'($random(seed)), $random(seed), random_vector(), random_vector(), 4'hf);
		for (int i = 0; i < ROLLBACK_ISSUES / 2; i++)
			issue_mem((i % 2 == 0) ? MEM_L : MEM_BX, 1'b0, thread_idx_t'($random(seed)), REG_PC,
				1'b0, LOAD_LINE_ADDR + 4 * i + i, '0, 4'hf);
		wait_idle();
		finish_test("pc rollback");

		for (int i = 0; i < CALL_ISSUES; i++)
			issue_arith(OP_CALL, thread_idx_t'(i), register_idx_t'($random(seed)),
				1'($random(seed)), $random(seed), random_vector(), random_vector(), 4'hf);
		wait_idle();
		for (int t = 0; t < NUM_THREADS; t++)
			for (int r = 0; r < NUM_REGS; r++)
				read_back(thread_idx_t'(t), register_idx_t'(r));
		wait_idle();
		finish_test("call");

		$display("Tests passed %0d, failed %0d; checks %0d, errors %0d",
			tests_passed, tests_failed, check_count, error_count);
		if (tests_failed == 0 && error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/wb_checker.sv ====
// Scoreboard that predicts rollbacks, register writes and readback for the pipeline tail
`timescale 1ns/1ps
`default_nettype none

module wb_checker import gpu_types_pkg::*; import gpu_ops_pkg::*;
#(
	parameter int CACHE_LINES = 16
)
(
	input wire logic clk,
	input wire logic reset,
	input wire logic issue_valid,
	input wire logic issue_is_mem,
	input alu_op_t issue_op,
	input memory_op_t issue_mem_op,
	input wire logic issue_is_store,
	input thread_idx_t issue_thread,
	input register_idx_t issue_dest_reg,
	input wire logic issue_dest_is_vector,
	input scalar_t issue_pc,
	input vector_t issue_operand_a,
	input vector_t issue_operand_b,
	input lane_mask_t issue_mask,
	input scalar_t issue_addr,
	input wire logic rollback_en,
	input thread_idx_t rollback_thread,
	input scalar_t rollback_pc,
	input pipeline_sel_t rollback_pipeline,
	input wire logic wb_en,
	input thread_idx_t wb_thread,
	input register_idx_t wb_reg,
	input wire logic wb_is_vector,
	input vector_t wb_value,
	input lane_mask_t wb_mask,
	input thread_idx_t read_thread,
	input register_idx_t read_reg,
	input vector_t read_value,
	input wire logic read_check,
	output int in_flight,
	output int check_count,
	output int error_count
);

	typedef struct packed
	{
		logic issued;
		logic rb_en;
		thread_idx_t rb_thread;
		scalar_t rb_pc;
		pipeline_sel_t rb_pipeline;
		logic wr_en;
		thread_idx_t wr_thread;
		register_idx_t wr_reg;
		logic wr_is_vector;
		vector_t wr_value;
		lane_mask_t wr_mask;
	} expect_t;

	// Byte-addressed copy of the cache, first byte of a word at the lower address
	logic [7:0] mem_model [CACHE_LINES * 16];
	vector_t reg_model [NUM_THREADS][NUM_REGS];
	expect_t rollback_queue [$];
	expect_t write_queue [$];

	function automatic int line_base(scalar_t addr);
		return (addr[11:4] % CACHE_LINES) * 16;
	endfunction

	function automatic scalar_t word_at(int index);
		return {mem_model[index], mem_model[index + 1], mem_model[index + 2],
			mem_model[index + 3]};
	endfunction

	function automatic expect_t reference_result(logic is_mem, alu_op_t op,
		memory_op_t mem_op, logic is_store, thread_idx_t thread, register_idx_t dest,
		logic dest_is_vector, scalar_t pc, vector_t a, vector_t b, lane_mask_t mask,
		scalar_t addr);
		expect_t e;
		int base;
		logic [7:0] byte_val;
		logic [15:0] half_val;
		scalar_t scalar_val;
		e = '0;
		e.issued = 1'b1;
		e.rb_thread = thread;
		e.wr_thread = thread;
		e.wr_reg = dest;
		e.wr_is_vector = dest_is_vector;
		e.wr_mask = mask;
		if (!is_mem)
		begin
			for (int lane = 0; lane < NUM_LANES; lane++)
			begin
				case (op)
					OP_ADD: e.wr_value[lane] = a[lane] + b[lane];
					OP_SUB: e.wr_value[lane] = a[lane] - b[lane];
					OP_MOVE: e.wr_value[lane] = b[lane];
					// One equality bit per lane, gathered in lane 0
					OP_CMPEQ: e.wr_value[0][lane] = a[lane] == b[lane];
					default: e.wr_value[lane] = pc + 32'd4;
				endcase
			end
			e.rb_pipeline = PIPE_SCYCLE_ARITH;
			if (op == OP_CALL)
			begin
				e.wr_reg = REG_LINK;
				e.wr_is_vector = 1'b0;
				e.wr_en = 1'b1;
				e.rb_en = 1'b1;
				e.rb_pc = a[0];
			end
			else if (dest == REG_PC)
			begin
				e.rb_en = 1'b1;
				e.rb_pc = e.wr_value[0];
			end
			else
				e.wr_en = 1'b1;
		end
		else if (!is_store)
		begin
			base = line_base(addr);
			byte_val = mem_model[base + addr[3:0]];
			half_val = {mem_model[base + {addr[3:1], 1'b0}], mem_model[base + {addr[3:1], 1'b1}]};
			case (mem_op)
				MEM_B: scalar_val = {24'b0, byte_val};
				MEM_BX: scalar_val = {{24{byte_val[7]}}, byte_val};
				MEM_S: scalar_val = {16'b0, half_val};
				MEM_SX: scalar_val = {{16{half_val[15]}}, half_val};
				default: scalar_val = word_at(base + 4 * addr[3:2]);
			endcase
			if (mem_op == MEM_BLOCK)
			begin
				// Each word comes back with its bytes in reverse order
				for (int w = 0; w < NUM_LANES; w++)
					e.wr_value[w] = {mem_model[base + 4 * w + 3], mem_model[base + 4 * w + 2],
						mem_model[base + 4 * w + 1], mem_model[base + 4 * w]};
			end
			else
			begin
				for (int lane = 0; lane < NUM_LANES; lane++)
					e.wr_value[lane] = scalar_val;
				e.wr_mask = '1;
			end
			e.rb_pipeline = PIPE_MEM;
			if (dest == REG_PC)
			begin
				e.rb_en = 1'b1;
				e.rb_pc = scalar_val;
			end
			else
				e.wr_en = 1'b1;
		end
		return e;
	endfunction

	task automatic store_word(int index, scalar_t value);
		for (int i = 0; i < 4; i++)
			mem_model[index + i] = value[31 - 8 * i -: 8];
	endtask

	task automatic apply_store(memory_op_t mem_op, scalar_t addr, vector_t b);
		int base;
		base = line_base(addr);
		if (mem_op == MEM_L)
			store_word(base + 4 * addr[3:2], b[0]);
		else if (mem_op == MEM_BLOCK)
		begin
			for (int w = 0; w < NUM_LANES; w++)
				store_word(base + 4 * w, b[w]);
		end
	endtask

	task automatic compare_field(string name, logic [127:0] expected, logic [127:0] actual);
		check_count++;
		if (expected !== actual)
		begin
			error_count++;
			$display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic compare_rollback(expect_t e);
		compare_field("rollback_en", e.rb_en, rollback_en);
		if (e.rb_en)
		begin
			compare_field("rollback_thread", e.rb_thread, rollback_thread);
			compare_field("rollback_pc", e.rb_pc, rollback_pc);
			compare_field("rollback_pipeline", e.rb_pipeline, rollback_pipeline);
		end
	endtask

	task automatic compare_write(expect_t e);
		compare_field("wb_en", e.wr_en, wb_en);
		if (e.wr_en)
		begin
			compare_field("wb_thread", e.wr_thread, wb_thread);
			compare_field("wb_reg", e.wr_reg, wb_reg);
			compare_field("wb_is_vector", e.wr_is_vector, wb_is_vector);
			compare_field("wb_value", e.wr_value, wb_value);
			compare_field("wb_mask", e.wr_mask, wb_mask);
		end
	endtask

	task automatic update_registers(expect_t e);
		if (e.wr_en && e.wr_is_vector)
		begin
			for (int lane = 0; lane < NUM_LANES; lane++)
				if (e.wr_mask[lane])
					reg_model[e.wr_thread][e.wr_reg][lane] = e.wr_value[lane];
		end
		else if (e.wr_en)
			reg_model[e.wr_thread][e.wr_reg][0] = e.wr_value[0];
	endtask

	// Sampled on the falling edge, half a cycle away from stimulus and DUT updates
	always @(negedge clk)
	begin : scoreboard
		expect_t e;
		if (reset)
		begin
			rollback_queue.delete();
			write_queue.delete();
			in_flight = 0;
			check_count = 0;
			error_count = 0;
			for (int i = 0; i < CACHE_LINES * 16; i++)
				mem_model[i] = 8'h00;
			for (int t = 0; t < NUM_THREADS; t++)
				for (int r = 0; r < NUM_REGS; r++)
					reg_model[t][r] = '0;
		end
		else
		begin
			// Write lands two cycles after issue
			if (write_queue.size() > 0)
			begin
				e = write_queue.pop_front();
				compare_write(e);
				update_registers(e);
				if (e.issued)
					in_flight--;
			end
			// Rollback one cycle after issue
			if (rollback_queue.size() > 0)
			begin
				e = rollback_queue.pop_front();
				compare_rollback(e);
				write_queue.push_back(e);
			end
			e = '0;
			if (issue_valid)
			begin
				e = reference_result(issue_is_mem, issue_op, issue_mem_op, issue_is_store,
					issue_thread, issue_dest_reg, issue_dest_is_vector, issue_pc,
					issue_operand_a, issue_operand_b, issue_mask, issue_addr);
				// Loads see the memory from before a store in the same slot
				if (issue_is_mem && issue_is_store)
					apply_store(issue_mem_op, issue_addr, issue_operand_b);
				in_flight++;
			end
			rollback_queue.push_back(e);
			if (read_check)
				compare_field("read_value", reg_model[read_thread][read_reg], read_value);
		end
	end

endmodule

`default_nettype wire

// ==== logic/writeback_subsystem.sv ====
// Pipeline tail top level joining both producer stages, writeback and registers
`timescale 1ns/1ps
`default_nettype none

module writeback_subsystem import gpu_types_pkg::*; import gpu_ops_pkg::*;
#(
	parameter int CACHE_LINES = 16
)
(
	input wire logic clk,
	input wire logic reset,
	input wire logic issue_valid,
	input wire logic issue_is_mem,
	input alu_op_t issue_op,
	input memory_op_t issue_mem_op,
	input wire logic issue_is_store,
	input thread_idx_t issue_thread,
	input register_idx_t issue_dest_reg,
	input wire logic issue_dest_is_vector,
	input scalar_t issue_pc,
	input vector_t issue_operand_a,
	input vector_t issue_operand_b,
	input lane_mask_t issue_mask,
	input scalar_t issue_addr,
	output logic rollback_en,
	output thread_idx_t rollback_thread,
	output scalar_t rollback_pc,
	output pipeline_sel_t rollback_pipeline,
	output logic wb_en,
	output thread_idx_t wb_thread,
	output register_idx_t wb_reg,
	output logic wb_is_vector,
	output vector_t wb_value,
	output lane_mask_t wb_mask,
	input thread_idx_t read_thread,
	input register_idx_t read_reg,
	output vector_t read_value
);

	sc_result_if sc_bus();
	dd_result_if dd_bus();
	reg_write_if wr_bus();

	// Each instruction is steered to exactly one producer stage
	single_cycle_stage u_single_cycle (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid && !issue_is_mem),
		.issue_op(issue_op),
		.issue_thread(issue_thread),
		.issue_dest_reg(issue_dest_reg),
		.issue_dest_is_vector(issue_dest_is_vector),
		.issue_pc(issue_pc),
		.issue_operand_a(issue_operand_a),
		.issue_operand_b(issue_operand_b),
		.issue_mask(issue_mask),
		.sc(sc_bus.producer)
	);

	dcache_data_stage #(.CACHE_LINES(CACHE_LINES)) u_dcache_data (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid && issue_is_mem),
		.issue_is_store(issue_is_store),
		.issue_mem_op(issue_mem_op),
		.issue_thread(issue_thread),
		.issue_dest_reg(issue_dest_reg),
		.issue_dest_is_vector(issue_dest_is_vector),
		.issue_addr(issue_addr),
		.issue_operand_b(issue_operand_b),
		.issue_mask(issue_mask),
		.dd(dd_bus.producer)
	);

	writeback_stage u_writeback (
		.clk(clk),
		.reset(reset),
		.sc(sc_bus.consumer),
		.dd(dd_bus.consumer),
		.rollback_en(rollback_en),
		.rollback_thread(rollback_thread),
		.rollback_pc(rollback_pc),
		.rollback_pipeline(rollback_pipeline),
		.wr(wr_bus.producer)
	);

	vector_register_file u_register_file (
		.clk(clk),
		.reset(reset),
		.wr(wr_bus.consumer),
		.read_thread(read_thread),
		.read_reg(read_reg),
		.read_value(read_value)
	);

	assign wb_en = wr_bus.en;
	assign wb_thread = wr_bus.thread;
	assign wb_reg = wr_bus.dest_reg;
	assign wb_is_vector = wr_bus.is_vector;
	assign wb_value = wr_bus.value;
	assign wb_mask = wr_bus.mask;

endmodule

`default_nettype wire

// ==== logic/vector_register_file.sv ====
// Vector register file with per-lane masked writes and one read port
`timescale 1ns/1ps
`default_nettype none

module vector_register_file import gpu_types_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	reg_write_if.consumer wr,
	input thread_idx_t read_thread,
	input register_idx_t read_reg,
	output vector_t read_value
);

	vector_t regs [NUM_THREADS][NUM_REGS];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int t = 0; t < NUM_THREADS; t++)
				for (int r = 0; r < NUM_REGS; r++)
					regs[t][r] <= '0;
		end
		else if (wr.en)
		begin
			if (wr.is_vector)
			begin
				for (int lane = 0; lane < NUM_LANES; lane++)
					if (wr.mask[lane])
						regs[wr.thread][wr.dest_reg][lane] <= wr.value[lane];
			end
			else
				// Scalar registers live in lane 0
				regs[wr.thread][wr.dest_reg][0] <= wr.value[0];
		end
	end

	assign read_value = regs[read_thread][read_reg];

endmodule

`default_nettype wire

// ==== logic/writeback_stage.sv ====
// Writeback stage with rollback select, load alignment and register write
`timescale 1ns/1ps
`default_nettype none

module writeback_stage import gpu_types_pkg::*; import gpu_ops_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	sc_result_if.consumer sc,
	dd_result_if.consumer dd,
	output logic rollback_en,
	output thread_idx_t rollback_thread,
	output scalar_t rollback_pc,
	output pipeline_sel_t rollback_pipeline,
	reg_write_if.producer wr
);

	memory_op_t mem_op;
	scalar_t load_word;
	logic [7:0] load_byte;
	logic [15:0] load_half;
	scalar_t aligned_value;
	vector_t swapped_line;
	vector_t compare_value;

	assign mem_op = memory_op_t'(dd.mem_op);
	assign load_word = dd.line_data[dd.request_addr[3:2]];

	// Big-endian byte within the word
	always_comb
	begin
		case (dd.request_addr[1:0])
			2'd0: load_byte = load_word[31:24];
			2'd1: load_byte = load_word[23:16];
			2'd2: load_byte = load_word[15:8];
			default: load_byte = load_word[7:0];
		endcase
	end

	assign load_half = dd.request_addr[1] ? load_word[15:0] : load_word[31:16];

	always_comb
	begin
		case (mem_op)
			MEM_B: aligned_value = {24'b0, load_byte};
			MEM_BX: aligned_value = {{24{load_byte[7]}}, load_byte};
			MEM_S: aligned_value = {16'b0, load_half};
			MEM_SX: aligned_value = {{16{load_half[15]}}, load_half};
			default: aligned_value = load_word;
		endcase
	end

	// Block loads come back with each word byte-reversed
	always_comb
	begin
		for (int lane = 0; lane < NUM_LANES; lane++)
			swapped_line[lane] = {dd.line_data[lane][7:0], dd.line_data[lane][15:8],
				dd.line_data[lane][23:16], dd.line_data[lane][31:24]};
	end

	always_comb
	begin
		compare_value = '0;
		for (int lane = 0; lane < NUM_LANES; lane++)
			compare_value[0][lane] = sc.result[lane][0];
	end

	// Kept combinational so the next issued instruction is cancelled in time
	always_comb
	begin
		rollback_en = 1'b0;
		rollback_thread = sc.thread;
		rollback_pc = sc.rollback_pc;
		rollback_pipeline = PIPE_SCYCLE_ARITH;
		if (sc.valid && sc.has_dest && sc.dest_reg == REG_PC)
		begin
			rollback_en = 1'b1;
			rollback_pc = sc.is_compare ? compare_value[0] : sc.result[0];
		end
		else if (dd.valid && dd.is_load && dd.dest_reg == REG_PC)
		begin
			rollback_en = 1'b1;
			rollback_thread = dd.thread;
			rollback_pc = aligned_value;
			rollback_pipeline = PIPE_MEM;
		end
		else if (sc.valid)
			rollback_en = sc.rollback_en;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			wr.en <= 1'b0;
		else if (sc.valid)
			// A call both rolls back and writes the link register
			wr.en <= sc.is_call || (sc.has_dest && !rollback_en);
		else if (dd.valid)
			wr.en <= dd.is_load && !rollback_en;
		else
			wr.en <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (sc.valid)
		begin
			wr.thread <= sc.thread;
			wr.dest_reg <= sc.dest_reg;
			wr.is_vector <= sc.dest_is_vector;
			wr.value <= sc.is_compare ? compare_value : sc.result;
			wr.mask <= sc.mask;
		end
		else if (dd.valid)
		begin
			wr.thread <= dd.thread;
			wr.dest_reg <= dd.dest_reg;
			wr.is_vector <= dd.dest_is_vector;
			if (mem_op == MEM_BLOCK)
			begin
				wr.value <= swapped_line;
				wr.mask <= dd.mask;
			end
			else
			begin
				wr.value <= {NUM_LANES{aligned_value}};
				wr.mask <= '1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/dcache_data_stage.sv ====
// Data cache data stage holding big-endian lines and registering load lines
`timescale 1ns/1ps
`default_nettype none

module dcache_data_stage import gpu_types_pkg::*; import gpu_ops_pkg::*;
#(
	parameter int CACHE_LINES = 16
)
(
	input wire logic clk,
	input wire logic reset,
	input wire logic issue_valid,
	input wire logic issue_is_store,
	input memory_op_t issue_mem_op,
	input thread_idx_t issue_thread,
	input register_idx_t issue_dest_reg,
	input wire logic issue_dest_is_vector,
	input scalar_t issue_addr,
	input vector_t issue_operand_b,
	input lane_mask_t issue_mask,
	dd_result_if.producer dd
);

	localparam int LINE_BITS = (CACHE_LINES > 1) ? $clog2(CACHE_LINES) : 1;

	// Word w of a line sits in lane w, its first byte in bits 31:24
	vector_t lines [CACHE_LINES];

	line_idx_t line_addr;
	logic [LINE_BITS - 1:0] line_sel;
	logic [1:0] word_sel;

	assign line_addr = issue_addr[4 +: $bits(line_idx_t)];
	assign line_sel = line_addr[LINE_BITS - 1:0];
	assign word_sel = issue_addr[3:2];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < CACHE_LINES; i++)
				lines[i] <= '0;
			dd.valid <= 1'b0;
		end
		else
		begin
			dd.valid <= issue_valid;
			if (issue_valid && issue_is_store)
			begin
				case (issue_mem_op)
					MEM_L: lines[line_sel][word_sel] <= issue_operand_b[0];
					MEM_BLOCK: lines[line_sel] <= issue_operand_b;
					default: ;
				endcase
			end
		end
	end

	// Load side sees the line as it was before this edge's store
	always_ff @(posedge clk)
	begin
		dd.thread <= issue_thread;
		dd.dest_reg <= issue_dest_reg;
		dd.dest_is_vector <= issue_dest_is_vector;
		dd.is_load <= !issue_is_store;
		dd.mem_op <= issue_mem_op;
		dd.mask <= issue_mask;
		dd.request_addr <= issue_addr;
		dd.line_data <= lines[line_sel];
	end

endmodule

`default_nettype wire

// ==== logic/single_cycle_stage.sv ====
// Single cycle arithmetic stage with lane-wise ops and call handling
`timescale 1ns/1ps
`default_nettype none

module single_cycle_stage import gpu_types_pkg::*; import gpu_ops_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic issue_valid,
	input alu_op_t issue_op,
	input thread_idx_t issue_thread,
	input register_idx_t issue_dest_reg,
	input wire logic issue_dest_is_vector,
	input scalar_t issue_pc,
	input vector_t issue_operand_a,
	input vector_t issue_operand_b,
	input lane_mask_t issue_mask,
	sc_result_if.producer sc
);

	vector_t lane_result;
	logic is_call;

	assign is_call = issue_op == OP_CALL;

	// Every op in this stage writes a register
	assign sc.has_dest = 1'b1;

	always_comb
	begin
		for (int lane = 0; lane < NUM_LANES; lane++)
		begin
			case (issue_op)
				OP_ADD: lane_result[lane] = issue_operand_a[lane] + issue_operand_b[lane];
				OP_SUB: lane_result[lane] = issue_operand_a[lane] - issue_operand_b[lane];
				OP_CMPEQ: lane_result[lane] = {31'b0, issue_operand_a[lane] == issue_operand_b[lane]};
				OP_MOVE: lane_result[lane] = issue_operand_b[lane];
				// Return address for the link register
				default: lane_result[lane] = issue_pc + 32'd4;
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			sc.valid <= 1'b0;
			sc.rollback_en <= 1'b0;
		end
		else
		begin
			sc.valid <= issue_valid;
			sc.rollback_en <= issue_valid && is_call;
		end
	end

	always_ff @(posedge clk)
	begin
		sc.thread <= issue_thread;
		sc.dest_reg <= is_call ? REG_LINK : issue_dest_reg;
		sc.dest_is_vector <= issue_dest_is_vector && !is_call;
		sc.is_compare <= issue_op == OP_CMPEQ;
		sc.is_call <= is_call;
		sc.result <= lane_result;
		sc.mask <= issue_mask;
		// Call target comes from lane 0 of the first operand
		sc.rollback_pc <= issue_operand_a[0];
	end

endmodule

`default_nettype wire

// ==== logic/stage_if.sv ====
// Result and register write buses between the pipeline tail stages
`timescale 1ns/1ps
`default_nettype none

interface sc_result_if import gpu_types_pkg::*; ();
	logic valid;
	thread_idx_t thread;
	register_idx_t dest_reg;
	logic has_dest;
	logic dest_is_vector;
	logic is_compare;
	logic is_call;
	vector_t result;
	lane_mask_t mask;
	logic rollback_en;
	scalar_t rollback_pc;

	modport producer(output valid, thread, dest_reg, has_dest, dest_is_vector, is_compare,
		is_call, result, mask, rollback_en, rollback_pc);
	modport consumer(input valid, thread, dest_reg, has_dest, dest_is_vector, is_compare,
		is_call, result, mask, rollback_en, rollback_pc);
endinterface

interface dd_result_if import gpu_types_pkg::*; ();
	logic valid;
	thread_idx_t thread;
	register_idx_t dest_reg;
	logic dest_is_vector;
	logic is_load;
	mem_op_code_t mem_op;
	lane_mask_t mask;
	scalar_t request_addr;
	vector_t line_data;

	modport producer(output valid, thread, dest_reg, dest_is_vector, is_load, mem_op, mask,
		request_addr, line_data);
	modport consumer(input valid, thread, dest_reg, dest_is_vector, is_load, mem_op, mask,
		request_addr, line_data);
endinterface

interface reg_write_if import gpu_types_pkg::*; ();
	logic en;
	thread_idx_t thread;
	register_idx_t dest_reg;
	logic is_vector;
	vector_t value;
	lane_mask_t mask;

	modport producer(output en, thread, dest_reg, is_vector, value, mask);
	modport consumer(input en, thread, dest_reg, is_vector, value, mask);
endinterface

`default_nettype wire

// ==== logic/gpu_ops_pkg.sv ====
// Operation and pipeline select encodings used across the pipeline tail
`default_nettype none

package gpu_ops_pkg;
	import gpu_types_pkg::*;

	typedef enum logic [2:0]
	{
		OP_ADD,
		OP_SUB,
		OP_CMPEQ,
		OP_MOVE,
		OP_CALL
	} alu_op_t;

	// Access width; the base type matches the code carried on dd_result_if
	typedef enum mem_op_code_t
	{
		MEM_B,
		MEM_BX,
		MEM_S,
		MEM_SX,
		MEM_L,
		MEM_BLOCK
	} memory_op_t;

	// Which pipeline a rollback came from
	typedef enum logic
	{
		PIPE_SCYCLE_ARITH,
		PIPE_MEM
	} pipeline_sel_t;

endpackage

`default_nettype wire

// ==== logic/gpu_types_pkg.sv ====
// Shared width types for lanes, threads, registers and cache lines
`default_nettype none

package gpu_types_pkg;

	localparam int NUM_LANES = 4;
	localparam int NUM_THREADS = 4;
	localparam int NUM_REGS = 32;

	// One lane value
	typedef logic [31:0] scalar_t;

	// Four lanes, lane 0 in the low bits; also one cache line
	typedef scalar_t [NUM_LANES - 1:0] vector_t;

	typedef logic [NUM_LANES - 1:0] lane_mask_t;
	typedef logic [$clog2(NUM_THREADS) - 1:0] thread_idx_t;
	typedef logic [$clog2(NUM_REGS) - 1:0] register_idx_t;

	// Cache line address field, taken from address bits 4 and up
	typedef logic [7:0] line_idx_t;

	// Encoding width of a memory op as it travels between stages
	typedef logic [2:0] mem_op_code_t;

	localparam register_idx_t REG_PC = 5'd31;
	localparam register_idx_t REG_LINK = 5'd30;

endpackage

`default_nettype wire
